/* rx_link.f */
common/rx_link_pkg.sv
design/rx_lane_gearbox.sv
design/rx_align_fsm.sv
design/rx_frame_select.sv
design/rx_link_top.sv
verif/tb_clkgen.sv
verif/tb_rx_link.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rx_link
FILELIST  ?= rx_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Pass message found in $(LOG)"; \
	else \
		echo "Pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_rx_link.sv */
`timescale 1ns/1ps

module tb_rx_link;

  localparam int LANES        = rx_link_pkg::LANES;
  localparam int SYM_W        = rx_link_pkg::SYM_W;
  localparam int FRAME_W      = rx_link_pkg::FRAME_W;
  localparam int FRAME_SYMS   = rx_link_pkg::SYMS_PER_FRAME;
  localparam int SEARCH_LIMIT = rx_link_pkg::SEARCH_LIMIT;
  localparam int MAX_EDGES    = 4096;
  localparam int RESET_WAIT   = 20;
  localparam int LOCK_WAIT    = SEARCH_LIMIT * FRAME_SYMS + 8;
  localparam int ERR_WAIT     = (SEARCH_LIMIT + 2) * FRAME_SYMS + 4;
  localparam int CLEAR_WAIT   = 8;

  // Training symbols in order of arrival.
  localparam logic [SYM_W-1:0] TRAIN [0:3] = '{10'h0FA, 10'h305, 10'h17C, 10'h283};

  logic                       clk;
  logic                       rst_n;
  logic                       cda_rdy;
  logic [LANES*SYM_W-1:0]     rx_word;
  logic [LANES*FRAME_W-1:0]   frame;
  logic                       frame_valid;
  logic                       data_locked;
  logic                       align_err;

  // Words per lane, indexed by the edge that samples them.
  logic [SYM_W-1:0] sent [0:MAX_EDGES-1][0:LANES-1];

  int   edge_cnt;
  int   rdy_ticks;
  int   seed;
  int   errors;
  int   timeouts;
  logic lane0_train;
  int   train_off;
  logic rdy_drv;

  tb_clkgen tb_clkgen_inst (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rx_link_top rx_link_top_inst (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_cda_rdy     (cda_rdy),
    .i_rx_word     (rx_word),
    .o_frame       (frame),
    .o_frame_valid (frame_valid),
    .o_data_locked (data_locked),
    .o_align_err   (align_err)
  );

  // Edges since reset release give the model's frame phase.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  //////////////////////////////
  // Checks.
  //////////////////////////////

  task automatic expect_level(input string name, input logic got, input logic want);
    assert (got === want) else begin
      errors++;
      $display("Error at %0t: %s expected %b got %b", $time, name, want, got);
    end
  endtask

  task automatic expect_idle_outputs();
    expect_level("o_frame_valid", frame_valid, 1'b0);
    expect_level("o_data_locked", data_locked, 1'b0);
    expect_level("o_align_err", align_err, 1'b0);
    assert (frame === '0) else begin
      errors++;
      $display("Error at %0t: o_frame expected 0 got %h", $time, frame);
    end
  endtask

  task automatic compare_frames(input int k);
    int               src;
    logic [SYM_W-1:0] got;
    logic [SYM_W-1:0] want;
    for (int l = 0; l < LANES; l++) begin
      for (int j = 0; j < FRAME_SYMS; j++) begin
        // Symbol j of a frame cut on tick edge n arrived on edge n-4-k+j.
        src  = edge_cnt - FRAME_SYMS - k + j;
        got  = frame[l*FRAME_W + j*SYM_W +: SYM_W];
        want = (l == 0) ? TRAIN[j] : sent[src][l];
        assert (got === want) else begin
          errors++;
          $display("Error at %0t: o_frame lane %0d symbol %0d expected %h got %h",
                   $time, l, j, want, got);
        end
      end
    end
  endtask

  //////////////////////////////
  // Stimulus and waits.
  //////////////////////////////

  // Enters and leaves on a falling edge.
  task automatic advance_cycle();
    int                     e;
    int                     rnd;
    logic [LANES*SYM_W-1:0] nxt;
    e = edge_cnt + 1;
    if (e < MAX_EDGES) begin
      for (int l = 0; l < LANES; l++) begin
        sent[e][l] = rx_word[l*SYM_W +: SYM_W];
      end
    end
    if (!cda_rdy) begin
      rdy_ticks = 0;
    end else if (e % FRAME_SYMS == 0) begin
      rdy_ticks++;
    end
    for (int l = 0; l < LANES; l++) begin
      rnd = $random(seed);
      nxt[l*SYM_W +: SYM_W] = rnd[SYM_W-1:0];
    end
    // Word 0 lands on edges where (edge + offset) is a multiple of 4.
    if (lane0_train) begin
      nxt[SYM_W-1:0] = TRAIN[(e + 1 + train_off) % FRAME_SYMS];
    end
    @(posedge clk);
    rx_word <= nxt;
    cda_rdy <= rdy_drv;
    @(negedge clk);
  endtask

  task automatic await_lock();
    int c;
    c = 0;
    while (data_locked !== 1'b1 && c < LOCK_WAIT) begin
      advance_cycle();
      expect_level("o_align_err", align_err, 1'b0);
      expect_level("o_frame_valid", frame_valid, 1'b0);
      c++;
    end
    if (data_locked !== 1'b1) begin
      timeouts++;
      $display("Timeout: o_data_locked did not rise within %0d cycles", LOCK_WAIT);
    end else begin
      assert (rdy_ticks <= SEARCH_LIMIT && edge_cnt % FRAME_SYMS == 0) else begin
        errors++;
        $display("Lock came at edge %0d after %0d ticks, off the tick rhythm or too late",
                 edge_cnt, rdy_ticks);
      end
    end
  endtask

  task automatic await_clear();
    int c;
    c = 0;
    while ((data_locked !== 1'b0 || align_err !== 1'b0) && c < CLEAR_WAIT) begin
      advance_cycle();
      c++;
    end
    if (data_locked !== 1'b0 || align_err !== 1'b0) begin
      timeouts++;
      $display("Timeout: lock and error flags did not clear within %0d cycles", CLEAR_WAIT);
    end
  endtask

  task automatic stream_frames(input int k, input int nframes);
    int pulses;
    pulses = 0;
    for (int c = 0; c < nframes * FRAME_SYMS; c++) begin
      advance_cycle();
      expect_level("o_frame_valid", frame_valid, (edge_cnt % FRAME_SYMS) == 0);
      expect_level("o_data_locked", data_locked, 1'b1);
      expect_level("o_align_err", align_err, 1'b0);
      if (frame_valid === 1'b1) begin
        pulses++;
        compare_frames(k);
      end
    end
    assert (pulses == nframes) else begin
      errors++;
      $display("Error at %0t: o_frame_valid pulses expected %0d got %0d",
               $time, nframes, pulses);
    end
  endtask

  //////////////////////////////
  // Directed tests.
  //////////////////////////////

  task automatic verify_reset_state();
    int c;
    c = 0;
    while (rst_n !== 1'b1 && c < RESET_WAIT) begin
      @(negedge clk);
      expect_idle_outputs();
      c++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was not released within %0d cycles", RESET_WAIT);
    end
    // Training present while ready stays low.
    lane0_train = 1'b1;
    train_off   = 0;
    rdy_drv     = 1'b0;
    for (int i = 0; i < 12; i++) begin
      advance_cycle();
      expect_idle_outputs();
    end
  endtask

  task automatic lock_at_offset(input int start);
    int k;
    k           = (FRAME_SYMS - start) % FRAME_SYMS;
    lane0_train = 1'b1;
    train_off   = k;
    rdy_drv     = 1'b0;
    repeat (8) advance_cycle();
    rdy_drv = 1'b1;
    await_lock();
    stream_frames(k, 6);
  endtask

  task automatic align_error_case();
    int c;
    lane0_train = 1'b0;
    rdy_drv     = 1'b0;
    repeat (8) advance_cycle();
    rdy_drv = 1'b1;
    c = 0;
    while (align_err !== 1'b1 && c < ERR_WAIT) begin
      advance_cycle();
      expect_level("o_align_err", align_err, rdy_ticks >= SEARCH_LIMIT);
      expect_level("o_data_locked", data_locked, 1'b0);
      expect_level("o_frame_valid", frame_valid, 1'b0);
      c++;
    end
    if (align_err !== 1'b1) begin
      timeouts++;
      $display("Timeout: o_align_err did not rise within %0d cycles", ERR_WAIT);
    end
    for (int i = 0; i < 8; i++) begin
      advance_cycle();
      expect_level("o_align_err", align_err, 1'b1);
      expect_level("o_data_locked", data_locked, 1'b0);
      expect_level("o_frame_valid", frame_valid, 1'b0);
    end
  endtask

  task automatic restart_link();
    lane0_train = 1'b1;
    train_off   = 2;
    rdy_drv     = 1'b0;
    await_clear();
    for (int i = 0; i < 8; i++) begin
      advance_cycle();
      expect_level("o_data_locked", data_locked, 1'b0);
      expect_level("o_align_err", align_err, 1'b0);
    end
    rdy_drv = 1'b1;
    await_lock();
    stream_frames(2, 4);
    // Drop ready while locked.
    rdy_drv = 1'b0;
    await_clear();
    for (int i = 0; i < 8; i++) begin
      advance_cycle();
      expect_level("o_frame_valid", frame_valid, 1'b0);
      expect_level("o_data_locked", data_locked, 1'b0);
    end
  endtask

  initial begin
    seed        = 5819;
    errors      = 0;
    timeouts    = 0;
    rdy_ticks   = 0;
    cda_rdy     = 1'b0;
    rx_word     = '0;
    lane0_train = 1'b0;
    train_off   = 0;
    rdy_drv     = 1'b0;

    verify_reset_state();
    for (int s = 0; s < FRAME_SYMS; s++) begin
      lock_at_offset(s);
    end
    align_error_case();
    restart_link();

    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // Release on a rising edge.
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

/* design/rx_link_top.sv */
`timescale 1ns/1ps

module rx_link_top (
  input  logic                                                    i_clk,
  input  logic                                                    i_rst_n,
  input  logic                                                    i_cda_rdy,
  input  logic [rx_link_pkg::LANES*rx_link_pkg::SYM_W-1:0]        i_rx_word,
  output logic [rx_link_pkg::LANES*rx_link_pkg::FRAME_W-1:0]      o_frame,
  output logic                                                    o_frame_valid,
  output logic                                                    o_data_locked,
  output logic                                                    o_align_err
);

  rx_link_pkg::lane_hist_t [rx_link_pkg::LANES-1:0] lane_hist;
  rx_link_pkg::frame_u     [rx_link_pkg::LANES-1:0] lane_frame;
  rx_link_pkg::offset_t                             offset;
  logic                                             frame_tick;

  //////////////////////////////
  // Word stream and phase.
  //////////////////////////////
  rx_lane_gearbox rx_lane_gearbox_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_word       (i_rx_word),
    .o_hist       (lane_hist),
    .o_frame_tick (frame_tick)
  );

  // Alignment runs on lane 0 only.
  rx_align_fsm rx_align_fsm_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cda_rdy    (i_cda_rdy),
    .i_hist0      (lane_hist[0]),
    .i_frame_tick (frame_tick),
    .o_offset     (offset),
    .o_locked     (o_data_locked),
    .o_align_err  (o_align_err)
  );

  //////////////////////////////
  // Aligned frames out.
  //////////////////////////////
  rx_frame_select rx_frame_select_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_hist        (lane_hist),
    .i_frame_tick  (frame_tick),
    .i_offset      (offset),
    .i_locked      (o_data_locked),
    .o_frame       (lane_frame),
    .o_frame_valid (o_frame_valid)
  );

  // Lane l occupies bits l*40 upward.
  for (genvar l = 0; l < rx_link_pkg::LANES; l++) begin : g_frame_out
    assign o_frame[l*rx_link_pkg::FRAME_W +: rx_link_pkg::FRAME_W] = lane_frame[l].raw;
  end

endmodule

/* design/rx_frame_select.sv */
`timescale 1ns/1ps

module rx_frame_select (
  input  logic                                               i_clk,
  input  logic                                               i_rst_n,
  input  rx_link_pkg::lane_hist_t [rx_link_pkg::LANES-1:0]   i_hist,
  input  logic                                               i_frame_tick,
  input  rx_link_pkg::offset_t                               i_offset,
  input  logic                                               i_locked,
  output rx_link_pkg::frame_u     [rx_link_pkg::LANES-1:0]   o_frame,
  output logic                                               o_frame_valid
);

  rx_link_pkg::frame_u [rx_link_pkg::LANES-1:0] cut;
  logic                                         take;

  //////////////////////////////
  // Offset mux per lane.
  //////////////////////////////

  always_comb begin
    for (int l = 0; l < rx_link_pkg::LANES; l++) begin
      cut[l] = rx_link_pkg::cut_frame(i_hist[l], i_offset);
    end
  end

  assign take = i_frame_tick && i_locked;

  //////////////////////////////
  // Output register.
  //////////////////////////////

  // Frames and valid land one cycle after the tick.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_frame       <= '0;
      o_frame_valid <= 1'b0;
    end else begin
      o_frame_valid <= take;
      if (take) begin
        o_frame <= cut;
      end
    end
  end

endmodule

/* design/rx_align_fsm.sv */
`timescale 1ns/1ps

module rx_align_fsm (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_cda_rdy,
  input  rx_link_pkg::lane_hist_t   i_hist0,
  input  logic                      i_frame_tick,
  output rx_link_pkg::offset_t      o_offset,
  output logic                      o_locked,
  output logic                      o_align_err
);

  logic [rx_link_pkg::STATE_W-1:0]      state;
  logic [rx_link_pkg::LOCK_CNT_W-1:0]   match_cnt;
  logic [rx_link_pkg::SEARCH_CNT_W-1:0] search_cnt;

  logic                 hit;
  rx_link_pkg::offset_t hit_off;
  logic                 same_off;
  logic                 lock_now;
  logic                 search_last;

  //////////////////////////////
  // Training match on lane 0.
  //////////////////////////////

  // Walk down so the lowest matching offset wins.
  always_comb begin
    rx_link_pkg::frame_u cand;
    hit     = 1'b0;
    hit_off = '0;
    for (int k = rx_link_pkg::SYMS_PER_FRAME - 1; k >= 0; k--) begin
      cand = rx_link_pkg::cut_frame(i_hist0, rx_link_pkg::offset_t'(k));
      if (cand.raw == rx_link_pkg::TRAIN_SEQ) begin
        hit     = 1'b1;
        hit_off = rx_link_pkg::offset_t'(k);
      end
    end
  end

  assign same_off    = hit && (state == rx_link_pkg::ST_CONFIRM) && (hit_off == o_offset);
  assign lock_now    = same_off && (match_cnt == rx_link_pkg::LOCK_COUNT - 1);
  assign search_last = (search_cnt == rx_link_pkg::SEARCH_LIMIT - 1);

  //////////////////////////////
  // State machine.
  //////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= rx_link_pkg::ST_IDLE;
      o_offset    <= '0;
      match_cnt   <= '0;
      search_cnt  <= '0;
      o_align_err <= 1'b0;
    end else if (!i_cda_rdy) begin
      // Dropping ready aborts everything.
      state       <= rx_link_pkg::ST_IDLE;
      o_offset    <= '0;
      match_cnt   <= '0;
      search_cnt  <= '0;
      o_align_err <= 1'b0;
    end else if (state != rx_link_pkg::ST_LOCKED) begin
      if (state == rx_link_pkg::ST_IDLE) begin
        state <= rx_link_pkg::ST_SEARCH;
      end
      if (i_frame_tick) begin
        // Tick count saturates at the limit.
        if (search_cnt != rx_link_pkg::SEARCH_LIMIT) begin
          search_cnt <= search_cnt + 1'b1;
        end
        // Error flag holds until ready drops.
        if (search_last && !lock_now) begin
          o_align_err <= 1'b1;
        end

        if (same_off) begin
          match_cnt <= match_cnt + 1'b1;
          if (lock_now) begin
            state <= rx_link_pkg::ST_LOCKED;
          end
        end else if (hit) begin
          // New candidate restarts the count at one.
          o_offset  <= hit_off;
          match_cnt <= 1'b1;
          state     <= rx_link_pkg::ST_CONFIRM;
        end else begin
          match_cnt <= '0;
          state     <= rx_link_pkg::ST_SEARCH;
        end
      end
    end
  end

  assign o_locked = (state == rx_link_pkg::ST_LOCKED);

endmodule

/* design/rx_lane_gearbox.sv */
`timescale 1ns/1ps

module rx_lane_gearbox (
  input  logic                                               i_clk,
  input  logic                                               i_rst_n,
  input  rx_link_pkg::symbol_t    [rx_link_pkg::LANES-1:0]   i_word,
  output rx_link_pkg::lane_hist_t [rx_link_pkg::LANES-1:0]   o_hist,
  output logic                                               o_frame_tick
);

  logic [rx_link_pkg::OFFSET_W-1:0] phase;

  //////////////////////////////
  // Word history per lane.
  //////////////////////////////

  // Newest word enters at entry 0, oldest drops off the top.
  always_ff @(posedge i_clk) begin
    for (int l = 0; l < rx_link_pkg::LANES; l++) begin
      o_hist[l] <= {o_hist[l][rx_link_pkg::HIST_DEPTH-2:0], i_word[l]};
    end
  end

  //////////////////////////////
  // Frame phase.
  //////////////////////////////

  // One counter shared by all lanes.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase <= '0;
    end else if (phase == rx_link_pkg::SYMS_PER_FRAME - 1) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // Last phase of each frame period.
  assign o_frame_tick = (phase == rx_link_pkg::SYMS_PER_FRAME - 1);

endmodule

/* common/rx_link_pkg.sv */
package rx_link_pkg;

  //////////////////////////////
  // Link geometry.
  //////////////////////////////
  localparam int LANES          = 4;
  localparam int SYM_W          = 10;
  localparam int SYMS_PER_FRAME = 4;
  localparam int FRAME_W        = SYM_W * SYMS_PER_FRAME;
  // Covers a frame at the largest offset.
  localparam int HIST_DEPTH     = 2 * SYMS_PER_FRAME - 1;
  localparam int OFFSET_W       = $clog2(SYMS_PER_FRAME);

  //////////////////////////////
  // Alignment control.
  //////////////////////////////
  localparam int LOCK_COUNT     = 3;
  localparam int LOCK_CNT_W     = $clog2(LOCK_COUNT + 1);
  localparam int SEARCH_LIMIT   = 16;
  localparam int SEARCH_CNT_W   = $clog2(SEARCH_LIMIT + 1);

  localparam int STATE_W        = 2;
  localparam logic [STATE_W-1:0] ST_IDLE    = 2'd0;
  localparam logic [STATE_W-1:0] ST_SEARCH  = 2'd1;
  localparam logic [STATE_W-1:0] ST_CONFIRM = 2'd2;
  localparam logic [STATE_W-1:0] ST_LOCKED  = 2'd3;

  typedef logic [SYM_W-1:0]    symbol_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  // Entry 0 is the newest word.
  typedef symbol_t [HIST_DEPTH-1:0] lane_hist_t;

  // Symbol 0 is the earliest arrival.
  typedef union packed {
    logic [FRAME_W-1:0]               raw;
    symbol_t [SYMS_PER_FRAME-1:0]     sym;
  } frame_u;

  // Training symbols in order of arrival.
  localparam symbol_t [SYMS_PER_FRAME-1:0] TRAIN_SEQ = {
    10'h283, 10'h17C, 10'h305, 10'h0FA
  };

  // Frame at offset k: symbol j is history entry k+3-j.
  function automatic frame_u cut_frame(lane_hist_t hist, offset_t offset);
    frame_u f;
    for (int j = 0; j < SYMS_PER_FRAME; j++) begin
      f.sym[j] = hist[int'(offset) + SYMS_PER_FRAME - 1 - j];
    end
    return f;
  endfunction

endpackage
